// ==== Bender.yml ====
package:
  name: ofilt

export_include_dirs:
  - .

sources:
  - ofilt_pkg.sv
  - cfg_port.sv
  - chan_param_bank.sv
  - output_filter.sv
  - filter_top.sv
  - target: test
    files:
      - filter_checker.sv
      - filter_tb.sv

// ==== build.f ====
+incdir+.
ofilt_pkg.sv
cfg_port.sv
chan_param_bank.sv
output_filter.sv
filter_top.sv
filter_checker.sv
filter_tb.sv

// ==== cfg_port.sv ====
`timescale 1ns/1ps

module cfg_port (
    input  logic                clk_in,
    input  logic                rst,
    // Four-phase host side
    input  logic                host_req,
    input  ofilt_pkg::host_wr_t host_wr,
    output logic                host_ack,
    // Write strobe to the parameter bank
    output logic                cfg_wr_en,
    output ofilt_pkg::host_wr_t cfg_wr
);

    ofilt_pkg::cfg_state_e state;
    ofilt_pkg::cfg_state_e state_next;

    // ----------------------------------------------------------
    // Handshake FSM
    // ----------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            // Wait for a new request
            ofilt_pkg::IDLE: begin
                if (host_req) begin
                    state_next = ofilt_pkg::WRITE;
                end
            end
            // Single strobe cycle
            ofilt_pkg::WRITE: begin
                state_next = ofilt_pkg::HOLD;
            end
            // Keep ack up until the host lets go of req
            ofilt_pkg::HOLD: begin
                if (!host_req) begin
                    state_next = ofilt_pkg::IDLE;
                end
            end
            default: begin
                state_next = ofilt_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state <= ofilt_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Capture the write when req is first seen
    always_ff @(posedge clk_in) begin
        if (state == ofilt_pkg::IDLE && host_req) begin
            cfg_wr <= host_wr;
        end
    end

    // Strobe and ack rise together
    assign cfg_wr_en = (state == ofilt_pkg::WRITE);
    assign host_ack  = (state != ofilt_pkg::IDLE);

endmodule

// ==== chan_param_bank.sv ====
`timescale 1ns/1ps
`include "ofilt_settings.svh"

module chan_param_bank (
    input  logic                                    clk_in,
    input  logic                                    rst,
    // Write strobe from the config port
    input  logic                                    cfg_wr_en,
    input  ofilt_pkg::host_wr_t                     cfg_wr,
    // Injection taken by the filter
    input  logic                                    inj_done,
    input  logic [`OFILT_W_CHAN-1:0]                inj_chan,
    // Per-channel view for the filter
    output ofilt_pkg::chan_cfg_t [`OFILT_N_CHAN-1:0] cfg_tab,
    output logic [`OFILT_N_CHAN-1:0]                inj_rqst,
    output logic [`OFILT_N_CHAN-1:0]                clr_rqst
);

    logic                     wr_hit;
    logic [`OFILT_N_CHAN-1:0] inj_next;
    logic [`OFILT_N_CHAN-1:0] clr_next;

    // Out-of-range channel writes are dropped
    assign wr_hit = cfg_wr_en && (int'(cfg_wr.chan) < `OFILT_N_CHAN);

    // ----------------------------------------------------------
    // Configuration registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_in) begin
        if (rst) begin
            cfg_tab <= '0;
        end else if (wr_hit) begin
            case (cfg_wr.addr)
                ofilt_pkg::CFG_MIN:  cfg_tab[cfg_wr.chan].min  <= cfg_wr.data;
                ofilt_pkg::CFG_MAX:  cfg_tab[cfg_wr.chan].max  <= cfg_wr.data;
                ofilt_pkg::CFG_INIT: cfg_tab[cfg_wr.chan].init <= cfg_wr.data;
                // Gain and shift use the low data bits
                ofilt_pkg::CFG_MULT: begin
                    cfg_tab[cfg_wr.chan].mult <= cfg_wr.data[`OFILT_W_MULT-1:0];
                end
                ofilt_pkg::CFG_RS: begin
                    cfg_tab[cfg_wr.chan].rs <= cfg_wr.data[`OFILT_W_RS-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Inject and clear requests
    // ----------------------------------------------------------
    always_comb begin
        inj_next = inj_rqst;
        clr_next = clr_rqst;
        if (wr_hit && cfg_wr.addr == ofilt_pkg::CFG_INJ) begin
            inj_next[cfg_wr.chan] = cfg_wr.data[0];
        end
        if (wr_hit && cfg_wr.addr == ofilt_pkg::CFG_CLR) begin
            clr_next[cfg_wr.chan] = cfg_wr.data[0];
        end
        // Filter took the injection
        if (inj_done) begin
            inj_next[inj_chan] = 1'b0;
        end
        // A clear cancels a pending inject and lasts one cycle
        inj_next = inj_next & ~clr_rqst;
        clr_next = clr_next & ~clr_rqst;
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            inj_rqst <= '0;
            clr_rqst <= '0;
        end else begin
            inj_rqst <= inj_next;
            clr_rqst <= clr_next;
        end
    end

endmodule

// ==== filter_checker.sv ====
`timescale 1ns/1ps
`include "ofilt_settings.svh"

module filter_checker (
    input logic                                     clk_in,
    input logic                                     rst,
    input logic                                     host_req,
    input logic                                     host_ack,
    input logic                                     cfg_wr_en,
    input logic                                     in_valid,
    input logic [`OFILT_N_CHAN-1:0]                 clr_rqst,
    input ofilt_pkg::chan_cfg_t [`OFILT_N_CHAN-1:0] cfg_tab,
    input logic                                     out_valid,
    input ofilt_pkg::result_t                       out_result
);

    // Failed assertions, read by the testbench at the end
    int fail_cnt = 0;

    // ----------------------------------------------------------
    // Host handshake and write strobe
    // ----------------------------------------------------------
    // New request gets ack on the next edge
    ack_follows_req: assert property (@(posedge clk_in) disable iff (rst)
        host_req && !host_ack |=> host_ack)
        else begin
            fail_cnt++;
            $error("host_ack did not follow host_req");
        end

    // Ack holds as long as req is up
    ack_holds_for_req: assert property (@(posedge clk_in) disable iff (rst)
        host_ack && host_req |=> host_ack)
        else begin
            fail_cnt++;
            $error("host_ack dropped while host_req was still high");
        end

    strobe_one_cycle: assert property (@(posedge clk_in) disable iff (rst)
        cfg_wr_en |=> !cfg_wr_en)
        else begin
            fail_cnt++;
            $error("cfg_wr_en lasted more than one cycle");
        end

    // Strobe and ack rise together
    strobe_with_ack: assert property (@(posedge clk_in) disable iff (rst)
        $rose(host_ack) |-> cfg_wr_en)
        else begin
            fail_cnt++;
            $error("host_ack rose without a write strobe");
        end

    // ----------------------------------------------------------
    // Datapath timing and bounds
    // ----------------------------------------------------------
    // Any clear in flight may kill the item, so skip those
    fixed_latency: assert property (@(posedge clk_in) disable iff (rst)
        (in_valid && clr_rqst == '0) ##1 (clr_rqst == '0) [*`OFILT_LATENCY-1]
        |=> out_valid)
        else begin
            fail_cnt++;
            $error("Accepted sample did not come out after the pipeline latency");
        end

    in_bounds: assert property (@(posedge clk_in) disable iff (rst)
        out_valid |->
            $signed(out_result.value) >= $signed(cfg_tab[out_result.chan].min) &&
            $signed(out_result.value) <= $signed(cfg_tab[out_result.chan].max))
        else begin
            fail_cnt++;
            $error("Output value outside the channel bounds");
        end

    // No output right out of reset
    quiet_after_reset: assert property (@(posedge clk_in)
        rst |=> !out_valid)
        else begin
            fail_cnt++;
            $error("out_valid high in the cycle after reset");
        end

endmodule

bind filter_top filter_checker u_filter_checker (
    .clk_in     (clk_in),
    .rst        (rst),
    .host_req   (host_req),
    .host_ack   (host_ack),
    .cfg_wr_en  (cfg_wr_en),
    .in_valid   (in_valid),
    .clr_rqst   (clr_rqst),
    .cfg_tab    (cfg_tab),
    .out_valid  (out_valid),
    .out_result (out_result)
);

// ==== filter_tb.sv ====
`timescale 1ns/1ps
`include "ofilt_settings.svh"

module filter_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_SKEW   = 2;
    // Rough length of each test in cycles
    localparam int CFG_CYCLES   = 300;
    localparam int ACC_CYCLES   = 300;
    localparam int CLAMP_CYCLES = 150;
    localparam int INJ_CYCLES   = 150;
    localparam int CLR_CYCLES   = 150;
    localparam int RUN_CYCLES   =
        2 * (CFG_CYCLES + ACC_CYCLES + CLAMP_CYCLES + INJ_CYCLES + CLR_CYCLES);
    localparam int HS_LIMIT     = 20;
    localparam int DRAIN_LIMIT  = 40;
    localparam int GAINS  [`OFILT_N_CHAN] = '{3, -5, 7, 127};
    localparam int SHIFTS [`OFILT_N_CHAN] = '{1, 2, 0, 4};

    // Expected result plus the edge its input was taken on
    typedef struct packed {
        ofilt_pkg::result_t res;
        int unsigned        k;
    } expect_t;

    logic                clk_in;
    logic                rst;
    logic                host_req;
    ofilt_pkg::host_wr_t host_wr;
    logic                host_ack;
    logic                in_valid;
    ofilt_pkg::sample_t  in_sample;
    logic                out_valid;
    ofilt_pkg::result_t  out_result;

    int          seed   = 76300;
    int unsigned cycle  = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests  = 0;
    expect_t     exp_q[$];

    // Reference model, one entry per channel
    int m_min  [`OFILT_N_CHAN];
    int m_max  [`OFILT_N_CHAN];
    int m_init [`OFILT_N_CHAN];
    int m_mult [`OFILT_N_CHAN];
    int m_rs   [`OFILT_N_CHAN];
    int m_prev [`OFILT_N_CHAN];

    filter_top u_filter_top (
        .clk_in     (clk_in),
        .rst        (rst),
        .host_req   (host_req),
        .host_wr    (host_wr),
        .host_ack   (host_ack),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    // Edge count, stable between edges
    always @(posedge clk_in) begin
        cycle <= cycle + 1;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", RUN_CYCLES);
        $display("Checks failed");
        $finish;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic step();
        @(posedge clk_in);
        #DRIVE_SKEW;
    endtask

    // Full four-phase write, strobes counted while ack is up
    task automatic host_write(ofilt_pkg::cfg_addr_e addr, int chan, int data);
        int waited;
        int strobes;
        waited  = 0;
        strobes = 0;
        host_wr.addr = addr;
        host_wr.chan = chan[`OFILT_W_CHAN-1:0];
        host_wr.data = data[`OFILT_W_DATA-1:0];
        host_req     = 1'b1;
        while (!host_ack && waited < HS_LIMIT) begin
            step();
            waited++;
            strobes += u_filter_top.cfg_wr_en;
        end
        host_req = 1'b0;
        while (host_ack && waited < HS_LIMIT) begin
            step();
            waited++;
            strobes += u_filter_top.cfg_wr_en;
        end
        if (waited >= HS_LIMIT) begin
            errors++;
            $display("Host write to %s never finished its handshake", addr.name());
        end
        checks++;
        assert (strobes == 1) else begin
            errors++;
            $display("CHECK FAILED time=%0t signal=cfg_wr_en got=%0d exp=1", $time, strobes);
        end
    endtask

    // Wait for every expected result to come out
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            step();
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results never came out", exp_q.size());
            exp_q.delete();
        end
    endtask

    // Config write, model follows once the pipe is empty
    task automatic set_reg(ofilt_pkg::cfg_addr_e addr, int chan, int value);
        drain();
        host_write(addr, chan, value);
        case (addr)
            ofilt_pkg::CFG_MIN:  m_min[chan]  = value;
            ofilt_pkg::CFG_MAX:  m_max[chan]  = value;
            ofilt_pkg::CFG_INIT: m_init[chan] = value;
            ofilt_pkg::CFG_MULT: m_mult[chan] = int'($signed(value[`OFILT_W_MULT-1:0]));
            ofilt_pkg::CFG_RS:   m_rs[chan]   = value & ((1 << `OFILT_W_RS) - 1);
            default: begin
            end
        endcase
    endtask

    // prev = clamp(prev + (delta * gain) >>> shift)
    task automatic send_sample(int chan, int delta);
        longint  sum;
        expect_t e;
        sum = m_prev[chan] + ((longint'(delta) * m_mult[chan]) >>> m_rs[chan]);
        if (sum > m_max[chan]) begin
            sum = m_max[chan];
        end else if (sum < m_min[chan]) begin
            sum = m_min[chan];
        end
        m_prev[chan] = int'(sum);
        e.res.chan   = chan[`OFILT_W_CHAN-1:0];
        e.res.value  = sum[`OFILT_W_DOUT-1:0];
        e.k          = cycle + 1;
        exp_q.push_back(e);
        in_sample.chan  = chan[`OFILT_W_CHAN-1:0];
        in_sample.delta = delta[`OFILT_W_DELTA-1:0];
        in_valid        = 1'b1;
        step();
        in_valid = 1'b0;
    endtask

    // Bit set two edges after req, enters on the following edge
    task automatic inject_channel(int chan);
        expect_t e;
        e.res.chan   = chan[`OFILT_W_CHAN-1:0];
        e.res.value  = m_init[chan][`OFILT_W_DOUT-1:0];
        e.k          = cycle + 3;
        exp_q.push_back(e);
        m_prev[chan] = m_init[chan];
        host_write(ofilt_pkg::CFG_INJ, chan, 1);
    endtask

    // Everything of this channel taken from one edge back is killed
    task automatic clear_channel(int chan);
        int unsigned first;
        first = cycle - 1;
        for (int i = exp_q.size() - 1; i >= 0; i--) begin
            if (exp_q[i].res.chan == chan && exp_q[i].k >= first) begin
                exp_q.delete(i);
            end
        end
        m_prev[chan] = m_init[chan];
        host_write(ofilt_pkg::CFG_CLR, chan, 1);
    endtask

    task automatic end_test(string name);
        drain();
        tests++;
        $display("Test %s finished, %0d errors so far", name, errors);
    endtask

    // ----------------------------------------------------------
    // Output monitor
    // ----------------------------------------------------------
    // Negedge sees the value the next rising edge takes
    always @(negedge clk_in) begin : monitor
        expect_t e;
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output on channel %0d came with no result expected", out_result.chan);
            end else begin
                e = exp_q.pop_front();
                checks++;
                assert (out_result == e.res) else begin
                    errors++;
                    $display("CHECK FAILED time=%0t signal=out_result got=%0d:%0d exp=%0d:%0d",
                        $time, out_result.chan, $signed(out_result.value),
                        e.res.chan, $signed(e.res.value));
                end
                assert (cycle + 1 == e.k + `OFILT_LATENCY) else begin
                    errors++;
                    $display("CHECK FAILED time=%0t signal=out_valid got=edge %0d exp=edge %0d",
                        $time, cycle + 1, e.k + `OFILT_LATENCY);
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------
    initial begin
        int r;
        int chan;
        int delta;
        rst       = 1'b1;
        host_req  = 1'b0;
        host_wr   = '0;
        in_valid  = 1'b0;
        in_sample = '0;
        for (int c = 0; c < `OFILT_N_CHAN; c++) begin
            m_min[c]  = 0;
            m_max[c]  = 0;
            m_init[c] = 0;
            m_mult[c] = 0;
            m_rs[c]   = 0;
            m_prev[c] = 0;
        end
        repeat (2) @(posedge clk_in);
        #DRIVE_SKEW;
        rst = 1'b0;

        // Bounds, gain and shift per channel
        for (int c = 0; c < `OFILT_N_CHAN; c++) begin
            set_reg(ofilt_pkg::CFG_MIN, c, -1048576);
            set_reg(ofilt_pkg::CFG_MAX, c, 1048575);
            set_reg(ofilt_pkg::CFG_MULT, c, GAINS[c]);
            set_reg(ofilt_pkg::CFG_RS, c, SHIFTS[c]);
        end
        for (int c = 0; c < `OFILT_N_CHAN; c++) begin
            send_sample(c, 1000);
            send_sample(c, -7);
            send_sample(c, -250);
        end
        end_test("config");

        // Random traffic with idle gaps and channel repeats
        repeat (80) begin
            r     = $random(seed);
            chan  = r & 3;
            delta = int'($signed(r[23:8]));
            send_sample(chan, delta);
            if (r[30:29] == 2'b00) begin
                step();
            end
        end
        repeat (4) begin
            r = $random(seed);
            send_sample(3, int'($signed(r[15:0])));
        end
        end_test("accumulate");

        // Drive channel 2 into both rails
        set_reg(ofilt_pkg::CFG_MIN, 2, -500);
        set_reg(ofilt_pkg::CFG_MAX, 2, 700);
        repeat (3) send_sample(2, 32000);
        send_sample(0, 40);
        repeat (3) send_sample(2, -32000);
        send_sample(2, 10);
        end_test("clamp");

        set_reg(ofilt_pkg::CFG_INIT, 1, 12345);
        inject_channel(1);
        send_sample(1, 200);
        send_sample(1, -40);
        set_reg(ofilt_pkg::CFG_INIT, 3, -777);
        inject_channel(3);
        send_sample(3, 100);
        send_sample(1, 3);
        end_test("inject");

        // Last two channel 0 samples are still in flight at the clear
        set_reg(ofilt_pkg::CFG_INIT, 0, 500);
        r = $random(seed);
        send_sample(1, int'($signed(r[15:0])));
        send_sample(0, int'($signed(r[31:16])));
        send_sample(1, 77);
        send_sample(0, -900);
        send_sample(0, 1200);
        send_sample(0, 333);
        clear_channel(0);
        send_sample(0, 50);
        send_sample(1, -60);
        send_sample(0, -20);
        send_sample(1, 15);
        end_test("clear");

        $display("Done: %0d tests, %0d checks, %0d errors, %0d assertion failures",
            tests, checks, errors, u_filter_top.u_filter_checker.fail_cnt);
        if (errors == 0 && u_filter_top.u_filter_checker.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== filter_top.sv ====
`timescale 1ns/1ps
`include "ofilt_settings.svh"

module filter_top (
    input  logic                clk_in,
    input  logic                rst,
    input  logic                host_req,
    input  ofilt_pkg::host_wr_t host_wr,
    output logic                host_ack,
    input  logic                in_valid,
    input  ofilt_pkg::sample_t  in_sample,
    output logic                out_valid,
    output ofilt_pkg::result_t  out_result
);

    logic                                    cfg_wr_en;
    ofilt_pkg::host_wr_t                     cfg_wr;
    ofilt_pkg::chan_cfg_t [`OFILT_N_CHAN-1:0] cfg_tab;
    logic [`OFILT_N_CHAN-1:0]                inj_rqst;
    logic [`OFILT_N_CHAN-1:0]                clr_rqst;
    logic                                    inj_done;
    logic [`OFILT_W_CHAN-1:0]                inj_chan;

    // Host handshake to write strobe
    cfg_port u_cfg_port (
        .clk_in    (clk_in),
        .rst       (rst),
        .host_req  (host_req),
        .host_wr   (host_wr),
        .host_ack  (host_ack),
        .cfg_wr_en (cfg_wr_en),
        .cfg_wr    (cfg_wr)
    );

    chan_param_bank u_param_bank (
        .clk_in    (clk_in),
        .rst       (rst),
        .cfg_wr_en (cfg_wr_en),
        .cfg_wr    (cfg_wr),
        .inj_done  (inj_done),
        .inj_chan  (inj_chan),
        .cfg_tab   (cfg_tab),
        .inj_rqst  (inj_rqst),
        .clr_rqst  (clr_rqst)
    );

    // Five-stage datapath
    output_filter u_output_filter (
        .clk_in     (clk_in),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .cfg_tab    (cfg_tab),
        .inj_rqst   (inj_rqst),
        .clr_rqst   (clr_rqst),
        .inj_done   (inj_done),
        .inj_chan   (inj_chan),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

// ==== ofilt_pkg.sv ====
`include "ofilt_settings.svh"

package ofilt_pkg;

    // Register select of a host write
    typedef enum logic [2:0] {
        CFG_MIN  = 3'd0,
        CFG_MAX  = 3'd1,
        CFG_INIT = 3'd2,
        CFG_MULT = 3'd3,
        CFG_RS   = 3'd4,
        CFG_INJ  = 3'd5,
        CFG_CLR  = 3'd6
    } cfg_addr_e;

    typedef struct packed {
        cfg_addr_e                  addr;
        logic [`OFILT_W_CHAN-1:0]   chan;
        logic [`OFILT_W_DATA-1:0]   data;
    } host_wr_t;

    // One channel's settings, bounds and init are signed
    typedef struct packed {
        logic signed [`OFILT_W_DOUT-1:0]  min;
        logic signed [`OFILT_W_DOUT-1:0]  max;
        logic signed [`OFILT_W_DOUT-1:0]  init;
        logic signed [`OFILT_W_MULT-1:0]  mult;
        logic [`OFILT_W_RS-1:0]           rs;
    } chan_cfg_t;

    typedef struct packed {
        logic [`OFILT_W_CHAN-1:0]         chan;
        logic signed [`OFILT_W_DELTA-1:0] delta;
    } sample_t;

    typedef struct packed {
        logic [`OFILT_W_CHAN-1:0]         chan;
        logic signed [`OFILT_W_DOUT-1:0]  value;
    } result_t;

    // Config port FSM
    typedef enum logic [1:0] {IDLE, WRITE, HOLD} cfg_state_e;

endpackage

// ==== ofilt_settings.svh ====
`ifndef OFILT_SETTINGS_SVH
`define OFILT_SETTINGS_SVH

// ----------------------------------------------------------
// Channel geometry
// ----------------------------------------------------------
`define OFILT_N_CHAN  4
`define OFILT_W_CHAN  2

// ----------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------
// Signed delta from the controller
`define OFILT_W_DELTA 16
`define OFILT_W_MULT  8
`define OFILT_W_RS    5
`define OFILT_W_DOUT  24
`define OFILT_W_DATA  24
// Input valid to output valid, in cycles
`define OFILT_LATENCY 5
`endif

// ==== output_filter.sv ====
`timescale 1ns/1ps
`include "ofilt_settings.svh"

module output_filter (
    input  logic                                    clk_in,
    input  logic                                    rst,
    input  logic                                    in_valid,
    input  ofilt_pkg::sample_t                      in_sample,
    input  ofilt_pkg::chan_cfg_t [`OFILT_N_CHAN-1:0] cfg_tab,
    input  logic [`OFILT_N_CHAN-1:0]                inj_rqst,
    input  logic [`OFILT_N_CHAN-1:0]                clr_rqst,
    output logic                                    inj_done,
    output logic [`OFILT_W_CHAN-1:0]                inj_chan,
    output logic                                    out_valid,
    output ofilt_pkg::result_t                      out_result
);

    localparam int W_PROD = `OFILT_W_DELTA + `OFILT_W_MULT;
    // One guard bit over the wider addend
    localparam int W_SUM = ((W_PROD > `OFILT_W_DOUT) ? W_PROD : `OFILT_W_DOUT) + 1;

    // Control that rides along each item
    typedef struct packed {
        logic                     vld;
        logic                     inj;
        logic [`OFILT_W_CHAN-1:0] chan;
    } ctl_t;

    // Drop the item if its channel is being cleared
    function automatic ctl_t advance(ctl_t c, logic [`OFILT_N_CHAN-1:0] clr);
        ctl_t n;
        n = c;
        if (clr[c.chan]) begin
            n.vld = 1'b0;
            n.inj = 1'b0;
        end
        return n;
    endfunction

    ctl_t sel_ctl, ctl_p1, ctl_p2, ctl_p3, ctl_p4;
    logic signed [`OFILT_W_DELTA-1:0] sel_delta, delta_p1;
    logic signed [`OFILT_W_MULT-1:0]  mult_p1;
    logic [`OFILT_W_RS-1:0]           rs_p1;
    logic signed [W_PROD-1:0]         prod_p1, dmtrs_p2, dmtrs_p3;
    logic signed [`OFILT_W_DOUT-1:0]  prev_p3, min_p3, max_p3, prev_eff;
    logic signed [W_SUM-1:0]          sum_p3;
    logic signed [`OFILT_W_DOUT-1:0]  clamp_p3, dout_p4, init_p4, wb_val;
    logic signed [`OFILT_W_DOUT-1:0]  prev_mem [`OFILT_N_CHAN];
    logic                             vld_p5;
    ofilt_pkg::result_t               res_p5;

    // ----------------------------------------------------------
    // Stage 1: pick input or injection, fetch gain and shift
    // ----------------------------------------------------------
    always_comb begin
        // Lowest pending channel wins
        inj_chan = '0;
        for (int i = `OFILT_N_CHAN - 1; i >= 0; i--) begin
            if (inj_rqst[i]) begin
                inj_chan = i[`OFILT_W_CHAN-1:0];
            end
        end
        // Only idle input cycles carry an injection
        inj_done     = !in_valid && |inj_rqst;
        sel_ctl.vld  = in_valid || inj_done;
        sel_ctl.inj  = inj_done;
        sel_ctl.chan = inj_done ? inj_chan : in_sample.chan;
        sel_delta    = inj_done ? '0 : in_sample.delta;
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            ctl_p1 <= '0;
        end else begin
            ctl_p1 <= advance(sel_ctl, clr_rqst);
        end
        delta_p1 <= sel_delta;
        mult_p1  <= cfg_tab[sel_ctl.chan].mult;
        rs_p1    <= cfg_tab[sel_ctl.chan].rs;
    end

    // ----------------------------------------------------------
    // Stage 2: gain and arithmetic shift
    // ----------------------------------------------------------
    assign prod_p1 = delta_p1 * mult_p1;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            ctl_p2 <= '0;
        end else begin
            ctl_p2 <= advance(ctl_p1, clr_rqst);
        end
        dmtrs_p2 <= prod_p1 >>> rs_p1;
    end

    // ----------------------------------------------------------
    // Stage 3: previous output and bounds
    // ----------------------------------------------------------
    // Item in p4 writes memory on this same edge, so bypass it
    always_ff @(posedge clk_in) begin
        if (rst) begin
            ctl_p3 <= '0;
        end else begin
            ctl_p3 <= advance(ctl_p2, clr_rqst);
        end
        dmtrs_p3 <= dmtrs_p2;
        if (ctl_p4.vld && ctl_p4.chan == ctl_p2.chan) begin
            prev_p3 <= wb_val;
        end else begin
            prev_p3 <= prev_mem[ctl_p2.chan];
        end
        min_p3 <= cfg_tab[ctl_p2.chan].min;
        max_p3 <= cfg_tab[ctl_p2.chan].max;
    end

    // ----------------------------------------------------------
    // Stage 4: accumulate and clamp
    // ----------------------------------------------------------
    always_comb begin
        // Item just ahead has not reached memory yet
        prev_eff = (ctl_p4.vld && ctl_p4.chan == ctl_p3.chan) ? wb_val : prev_p3;
        sum_p3   = dmtrs_p3 + prev_eff;
        if (sum_p3 > max_p3) begin
            clamp_p3 = max_p3;
        end else if (sum_p3 < min_p3) begin
            clamp_p3 = min_p3;
        end else begin
            clamp_p3 = sum_p3[`OFILT_W_DOUT-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            ctl_p4 <= '0;
        end else begin
            ctl_p4 <= advance(ctl_p3, clr_rqst);
        end
        dout_p4 <= clamp_p3;
        init_p4 <= cfg_tab[ctl_p3.chan].init;
    end

    // ----------------------------------------------------------
    // Stage 5: init select, write back, output register
    // ----------------------------------------------------------
    assign wb_val = ctl_p4.inj ? init_p4 : dout_p4;

    // Clear reload overrides a same-cycle write back
    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int i = 0; i < `OFILT_N_CHAN; i++) begin
                prev_mem[i] <= '0;
            end
        end else begin
            if (ctl_p4.vld) begin
                prev_mem[ctl_p4.chan] <= wb_val;
            end
            for (int i = 0; i < `OFILT_N_CHAN; i++) begin
                if (clr_rqst[i]) begin
                    prev_mem[i] <= cfg_tab[i].init;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst) begin
            vld_p5 <= 1'b0;
        end else begin
            vld_p5 <= ctl_p4.vld && !clr_rqst[ctl_p4.chan];
        end
        res_p5.chan  <= ctl_p4.chan;
        res_p5.value <= wb_val;
    end

    assign out_valid  = vld_p5;
    assign out_result = res_p5;

endmodule
